/* compile.f */
+incdir+hw
hw/hexcmd_pkg.sv
hw/wb_if.sv
hw/cmd_parser.sv
hw/hex_field_reg.sv
hw/bus_timer.sv
hw/wb_master.sv
hw/reg_bank.sv
hw/hex_reply.sv
hw/hexcmd_top.sv
sim/tb_hexcmd.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       := tb_hexcmd
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_hexcmd.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_hexcmd;

    localparam int WAIT_LIMIT = 200;

    logic        clk;
    logic        rst_n;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic        rx_ready;
    logic [7:0]  tx_data;
    logic        tx_valid;
    logic        tx_ready;

    // Expected contents of the register bank
    logic [31:0] model [16];

    integer      seed;
    int          err_count;
    int          check_count;
    logic        stall_en;
    int          stall_left;

    hexcmd_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ******************************
    // Helpers
    // ******************************
    task automatic report_and_finish;
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        err_count++;
        $display("Timeout: %s", what);
        report_and_finish();
    endtask

    // ASCII hex digit in the case the caller picks
    function automatic logic [7:0] hex_digit(input logic [3:0] n, input logic lower);
        if (n < 4'd10)
            return 8'h30 + {4'h0, n};
        else if (lower)
            return 8'h61 + {4'h0, n} - 8'd10;
        else
            return 8'h41 + {4'h0, n} - 8'd10;
    endfunction

    // Random low and high stretches of tx_ready, one step per rising edge
    task automatic drive_tx_ready;
        if (!stall_en) begin
            tx_ready <= 1'b1;
        end else if (stall_left > 0) begin
            stall_left--;
        end else begin
            tx_ready   <= !tx_ready;
            stall_left = tx_ready ? {$random(seed)} % 6 : {$random(seed)} % 3;
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        int waited;
        waited = 0;
        @(posedge clk);
        rx_data  <= b;
        rx_valid <= 1'b1;
        @(negedge clk);
        while (!rx_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (rx_ready) begin
            @(posedge clk);
            rx_valid <= 1'b0;
        end else begin
            abort_on_timeout($sformatf("input byte %h was never accepted", b));
        end
    endtask

    task automatic expect_byte(input string name, input logic [7:0] exp);
        int         waited;
        logic       got;
        logic [7:0] act;
        got    = 1'b0;
        act    = 8'h00;
        waited = 0;
        while (!got && waited < WAIT_LIMIT) begin
            @(negedge clk);
            got = tx_valid && tx_ready;
            act = tx_data;
            @(posedge clk);
            drive_tx_ready();
            waited++;
        end
        if (got) begin
            check_count++;
            if (act !== exp) begin
                err_count++;
                $display("ERR %s expected %h actual %h", name, exp, act);
            end
        end else begin
            abort_on_timeout($sformatf("no output byte arrived in %s", name));
        end
    endtask

    task automatic send_cmd(input string name, input string cmd);
        for (int i = 0; i < cmd.len(); i++) begin
            send_byte(cmd[i]);
            expect_byte(name, cmd[i]);
        end
    endtask

    task automatic expect_silence(input string name, input int cycles);
        logic       seen;
        logic [7:0] extra;
        seen  = 1'b0;
        extra = 8'h00;
        repeat (cycles) begin
            @(negedge clk);
            if (tx_valid && !seen) begin
                seen  = 1'b1;
                extra = tx_data;
            end
        end
        check_count++;
        if (seen) begin
            err_count++;
            $display("%s: unexpected output byte %h when nothing was due", name, extra);
        end
    endtask

    task automatic wait_for_ready(input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!rx_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        check_count++;
        if (!rx_ready)
            abort_on_timeout($sformatf("rx_ready stayed low after %s", name));
    endtask

    // Eight upper-case digits, most significant first, then CR
    task automatic read_and_compare(input string name, input logic [3:0] a);
        send_cmd(name, $sformatf("r%02h", {4'h0, a}));
        for (int i = 7; i >= 0; i--)
            expect_byte(name, hex_digit(model[a][i*4 +: 4], 1'b0));
        expect_byte(name, 8'h0D);
    endtask

    // ******************************
    // Directed tests
    // ******************************
    task automatic echo_plain;
        logic [7:0] c;
        for (int i = 0; i < 12; i++) begin
            c = 8'h20 + 8'({$random(seed)} % 95);
            if (c == "w" || c == "r")
                c = "x";
            send_byte(c);
            expect_byte("echo", c);
        end
        expect_silence("echo", 20);
    endtask

    task automatic write_full;
        logic [3:0]  a;
        logic [31:0] d;
        string       cmd;
        a   = 4'($random(seed));
        d   = $random(seed);
        cmd = $sformatf("w%02h", {4'h0, a});
        // Mixed case data digits
        for (int i = 7; i >= 0; i--)
            cmd = $sformatf("%s%c", cmd, hex_digit(d[i*4 +: 4], 1'($random(seed))));
        send_cmd("full write", cmd);
        model[a] = d;
        read_and_compare("full read", a);
    endtask

    task automatic write_short;
        logic [11:0] d;
        string       cmd;
        d   = 12'($random(seed));
        cmd = "w05";
        for (int i = 2; i >= 0; i--)
            cmd = $sformatf("%s%c", cmd, hex_digit(d[i*4 +: 4], 1'($random(seed))));
        cmd = $sformatf("%s ", cmd);
        send_cmd("short write", cmd);
        model[5] = {20'h0, d};
        read_and_compare("short read", 4'd5);
    endtask

    task automatic abort_commands;
        // Nonzero so that a stray write of the cleared fields to register 0 shows
        send_cmd("abort setup", "w00C3a5E1f0");
        model[0] = 32'hC3A5E1F0;
        send_cmd("abort read", "rz");
        send_cmd("abort write", "w.");
        // Longer than the bus timeout so that a stray access shows
        expect_silence("abort", 40);
        read_and_compare("abort readback", 4'd5);
        read_and_compare("abort readback", 4'd0);
    endtask

    task automatic read_unmapped;
        send_cmd("unmapped", "r40");
        expect_byte("unmapped", "!");
        wait_for_ready("unmapped read");
        expect_silence("unmapped", 10);
    endtask

    task automatic read_backpressure;
        logic [3:0]  a;
        logic [31:0] d;
        a = 4'($random(seed));
        d = $random(seed);
        send_cmd("bp write", $sformatf("w%02h%08h", {4'h0, a}, d));
        model[a]   = d;
        stall_left = 0;
        stall_en   = 1'b1;
        read_and_compare("backpressure", a);
        stall_en   = 1'b0;
        expect_silence("backpressure", 20);
    endtask

    initial begin
        seed        = 96;
        err_count   = 0;
        check_count = 0;
        stall_en    = 1'b0;
        stall_left  = 0;
        rst_n       = 1'b0;
        rx_data     = 8'h00;
        rx_valid    = 1'b0;
        tx_ready    = 1'b1;
        for (int i = 0; i < 16; i++)
            model[i] = '0;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_count++;
        if (!rx_ready || tx_valid) begin
            err_count++;
            $display("ERR reset expected rx_ready=1 tx_valid=0 actual rx_ready=%b tx_valid=%b",
                     rx_ready, tx_valid);
        end

        echo_plain();
        write_full();
        write_short();
        abort_commands();
        read_unmapped();
        read_backpressure();

        report_and_finish();
    end

endmodule

`default_nettype wire

/* hw/hexcmd_top.sv */
`timescale 1ns/10ps
`default_nettype none

module hexcmd_top
    import hexcmd_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  char_t rx_data,
    input  logic  rx_valid,
    output logic  rx_ready,
    output char_t tx_data,
    output logic  tx_valid,
    input  logic  tx_ready
);

    logic  accept;
    logic  clear, push_addr, push_data, commit_write, commit_read;
    logic  bus_busy, read_done, timed_out, reply_busy;
    addr_t addr;
    data_t wdata, rdata;

    wb_if bus ();

    // Result pulse still on its way to the reply block counts as busy
    assign rx_ready = !bus_busy && !reply_busy && !(read_done || timed_out);
    assign accept   = rx_valid && rx_ready;

    cmd_parser u_parser (
        .clk(clk), .rst_n(rst_n), .byte_in(rx_data), .accept(accept),
        .clear(clear), .push_addr(push_addr), .push_data(push_data),
        .commit_write(commit_write), .commit_read(commit_read)
    );

    hex_field_reg #(.WIDTH($bits(addr_t))) u_addr_field (
        .clk(clk), .rst_n(rst_n), .byte_in(rx_data),
        .clear(clear), .push(push_addr), .value(addr)
    );

    hex_field_reg #(.WIDTH($bits(data_t))) u_data_field (
        .clk(clk), .rst_n(rst_n), .byte_in(rx_data),
        .clear(clear), .push(push_data), .value(wdata)
    );

    wb_master u_master (
        .clk(clk), .rst_n(rst_n), .start_write(commit_write), .start_read(commit_read),
        .addr(addr), .wdata(wdata), .wb(bus.master), .busy(bus_busy),
        .read_done(read_done), .timed_out(timed_out), .rdata(rdata)
    );

    reg_bank u_regs (
        .clk(clk), .rst_n(rst_n), .wb(bus.slave)
    );

    hex_reply u_reply (
        .clk(clk), .rst_n(rst_n), .echo_byte(rx_data), .echo(accept),
        .read_done(read_done), .rdata(rdata), .timed_out(timed_out), .busy(reply_busy),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready)
    );

endmodule

`default_nettype wire

/* hw/hex_reply.sv */
`timescale 1ns/10ps
`default_nettype none

module hex_reply
    import hexcmd_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  char_t echo_byte,
    input  logic  echo,
    input  logic  read_done,
    input  data_t rdata,
    input  logic  timed_out,
    output logic  busy,
    output char_t tx_data,
    output logic  tx_valid,
    input  logic  tx_ready
);

    data_t      shift;
    logic [3:0] left;
    logic       bang;
    logic       slot_free;
    logic       load_digit, load_cr, load_bang;
    nibble_t    top_nib;

    assign slot_free  = !tx_valid || tx_ready;
    assign load_digit = !echo && slot_free && (left > 4'd1);
    assign load_cr    = !echo && slot_free && (left == 4'd1);
    assign load_bang  = !echo && slot_free && (left == 4'd0) && bang;
    assign top_nib    = shift[$bits(data_t)-1 -: 4];
    assign busy       = tx_valid || (left != 4'd0) || bang;

    // ******************************
    // Control
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_valid <= 1'b0;
            left     <= 4'd0;
            bang     <= 1'b0;
        end else begin
            if (echo || load_digit || load_cr || load_bang)
                tx_valid <= 1'b1;
            else if (tx_ready)
                tx_valid <= 1'b0;
            // Eight digits then CR
            if (read_done)
                left <= 4'd9;
            else if (load_digit || load_cr)
                left <= left - 4'd1;
            if (timed_out)
                bang <= 1'b1;
            else if (load_bang)
                bang <= 1'b0;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (echo)
            tx_data <= echo_byte;
        else if (load_digit)
            tx_data <= (top_nib < 4'd10) ? char_t'(8'h30 + top_nib) : char_t'(8'h37 + top_nib);
        else if (load_cr)
            tx_data <= 8'h0D;
        else if (load_bang)
            tx_data <= 8'h21;

        if (read_done)
            shift <= rdata;
        else if (load_digit)
            shift <= shift << 4;
    end

    a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)));

endmodule

`default_nettype wire

/* hw/reg_bank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hexcmd_defines.svh"

module reg_bank
    import hexcmd_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    wb_if.slave  wb
);

    localparam int IDX_W = $clog2(`HEXCMD_NREGS);

    data_t             regs [`HEXCMD_NREGS];
    logic              hit;
    logic [IDX_W-1:0]  idx;

    assign hit      = (wb.adr < `HEXCMD_NREGS);
    assign idx      = wb.adr[IDX_W-1:0];
    assign wb.dat_r = regs[idx];

    // One wait state, ack in the second cycle of stb
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb.ack <= 1'b0;
        else
            wb.ack <= wb.cyc && wb.stb && hit && !wb.ack;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `HEXCMD_NREGS; i++)
                regs[i] <= '0;
        end else if (wb.ack && wb.we) begin
            regs[idx] <= wb.dat_w;
        end
    end

    a_ack_in_stb: assert property (@(posedge clk) disable iff (!rst_n)
        wb.ack |-> wb.stb);

endmodule

`default_nettype wire

/* hw/wb_master.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_master
    import hexcmd_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start_write,
    input  logic  start_read,
    input  addr_t addr,
    input  data_t wdata,
    wb_if.master  wb,
    output logic  busy,
    output logic  read_done,
    output logic  timed_out,
    output data_t rdata
);

    bus_state_e state;
    logic       expired;

    bus_timer u_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (state == B_BUSY),
        .expired (expired)
    );

    // Fields are frozen while busy since rx_ready is low
    assign wb.adr   = addr;
    assign wb.dat_w = wdata;
    assign busy     = (state == B_BUSY);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= B_IDLE;
            wb.cyc    <= 1'b0;
            wb.stb    <= 1'b0;
            wb.we     <= 1'b0;
            read_done <= 1'b0;
            timed_out <= 1'b0;
        end else begin
            read_done <= 1'b0;
            timed_out <= 1'b0;
            case (state)
                B_IDLE: begin
                    if (start_write || start_read) begin
                        state  <= B_BUSY;
                        wb.cyc <= 1'b1;
                        wb.stb <= 1'b1;
                        wb.we  <= start_write;
                    end
                end
                B_BUSY: begin
                    if (wb.ack || expired) begin
                        state     <= B_IDLE;
                        wb.cyc    <= 1'b0;
                        wb.stb    <= 1'b0;
                        read_done <= wb.ack && !wb.we;
                        timed_out <= !wb.ack;
                    end
                end
                default: state <= B_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == B_BUSY && wb.ack && !wb.we)
            rdata <= wb.dat_r;
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb.stb |-> wb.cyc);

    // Address must hold for the whole wait, it comes straight from the field
    a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb.stb && !wb.ack && !expired) |=> $stable(wb.adr));

endmodule

`default_nettype wire

/* hw/bus_timer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hexcmd_defines.svh"

module bus_timer
    import hexcmd_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic expired
);

    localparam int CNT_W = $clog2(`HEXCMD_BUS_TIMEOUT + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            count <= '0;
        else if (!run)
            count <= '0;
        else if (!expired)
            count <= count + 1'b1;
    end

    assign expired = (count == CNT_W'(`HEXCMD_BUS_TIMEOUT));

endmodule

`default_nettype wire

/* hw/hex_field_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module hex_field_reg
    import hexcmd_pkg::*;
#(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  char_t            byte_in,
    input  logic             clear,
    input  logic             push,
    output logic [WIDTH-1:0] value
);

    nibble_t nib;

    // Digit ranges already checked by the parser
    always_comb begin
        if (byte_in <= 8'h39)
            nib = nibble_t'(byte_in - 8'h30);
        else if (byte_in <= 8'h46)
            nib = nibble_t'(byte_in - 8'h37);
        else
            nib = nibble_t'(byte_in - 8'h57);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            value <= '0;
        else if (clear)
            value <= '0;
        else if (push)
            value <= {value[WIDTH-5:0], nib};
    end

endmodule

`default_nettype wire

/* hw/cmd_parser.sv */
`timescale 1ns/10ps
`default_nettype none

module cmd_parser
    import hexcmd_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  char_t byte_in,
    input  logic  accept,
    output logic  clear,
    output logic  push_addr,
    output logic  push_data,
    output logic  commit_write,
    output logic  commit_read
);

    localparam char_t CHR_W = 8'h77;
    localparam char_t CHR_R = 8'h72;

    parse_state_e state, state_n;
    logic         is_hex;

    // 0-9, A-F, a-f
    assign is_hex = (byte_in >= 8'h30 && byte_in <= 8'h39) ||
                    (byte_in >= 8'h41 && byte_in <= 8'h46) ||
                    (byte_in >= 8'h61 && byte_in <= 8'h66);

    // ******************************
    // Next state and strobes
    // ******************************
    always_comb begin
        state_n      = state;
        clear        = 1'b0;
        push_addr    = 1'b0;
        push_data    = 1'b0;
        commit_write = 1'b0;
        commit_read  = 1'b0;
        if (accept) begin
            case (state)
                P_IDLE: begin
                    clear = 1'b1;
                    if (byte_in == CHR_W)
                        state_n = P_WADDR0;
                    else if (byte_in == CHR_R)
                        state_n = P_RADDR0;
                end
                P_WADDR0, P_RADDR0: begin
                    // Bad first digit just abandons the command
                    push_addr = is_hex;
                    if (!is_hex)
                        state_n = P_IDLE;
                    else
                        state_n = (state == P_WADDR0) ? P_WADDR1 : P_RADDR1;
                end
                P_WADDR1: begin
                    push_addr    = is_hex;
                    commit_write = !is_hex;
                    state_n      = is_hex ? P_WDATA0 : P_IDLE;
                end
                P_RADDR1: begin
                    push_addr   = is_hex;
                    commit_read = 1'b1;
                    state_n     = P_IDLE;
                end
                P_WDATA7: begin
                    push_data    = is_hex;
                    commit_write = 1'b1;
                    state_n      = P_IDLE;
                end
                default: begin
                    // P_WDATA0 .. P_WDATA6
                    push_data    = is_hex;
                    commit_write = !is_hex;
                    state_n      = is_hex ? parse_state_e'(state + 4'd1) : P_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= P_IDLE;
        else
            state <= state_n;
    end

endmodule

`default_nettype wire

/* hw/wb_if.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hexcmd_defines.svh"

interface wb_if;

    logic [`HEXCMD_ADDR_W-1:0] adr;
    logic [`HEXCMD_DATA_W-1:0] dat_w;
    logic [`HEXCMD_DATA_W-1:0] dat_r;
    logic                      we;
    logic                      cyc;
    logic                      stb;
    logic                      ack;

    modport master (output adr, dat_w, we, cyc, stb, input dat_r, ack);
    modport slave  (input adr, dat_w, we, cyc, stb, output dat_r, ack);

endinterface

`default_nettype wire

/* hw/hexcmd_pkg.sv */
`default_nettype none

`include "hexcmd_defines.svh"

package hexcmd_pkg;

    typedef logic [7:0]                  char_t;
    typedef logic [3:0]                  nibble_t;
    typedef logic [`HEXCMD_ADDR_W-1:0]   addr_t;
    typedef logic [`HEXCMD_DATA_W-1:0]   data_t;

    // Order matters, write data states are stepped by +1
    typedef enum logic [3:0] {
        P_IDLE,
        P_WADDR0, P_WADDR1,
        P_WDATA0, P_WDATA1, P_WDATA2, P_WDATA3,
        P_WDATA4, P_WDATA5, P_WDATA6, P_WDATA7,
        P_RADDR0, P_RADDR1
    } parse_state_e;

    typedef enum logic {B_IDLE, B_BUSY} bus_state_e;

endpackage

`default_nettype wire

/* hw/hexcmd_defines.svh */
`ifndef HEXCMD_DEFINES_SVH
`define HEXCMD_DEFINES_SVH

// Bus widths
`define HEXCMD_ADDR_W 8
`define HEXCMD_DATA_W 32

// Registers in the bank
`define HEXCMD_NREGS 16

// Wait cycles before a bus abort
`define HEXCMD_BUS_TIMEOUT 16

`endif
